//--- oflow_iou_defs.svh
// overlap engine widths and register map
`ifndef OFLOW_IOU_DEFS_SVH
`define OFLOW_IOU_DEFS_SVH

// datapath widths
`define COORD_LEN 10
`define AREA_LEN 20
`define FRAC_LEN 16
// one integer bit so a ratio of exactly one fits
`define QUOT_LEN (`FRAC_LEN + 1)

// apb bus widths
`define APB_ADDR_LEN 8
`define APB_DATA_LEN 32

// register offsets
`define ADDR_K_TL 8'h00
`define ADDR_K_BR 8'h04
`define ADDR_H_TL 8'h08
`define ADDR_H_BR 8'h0C
`define ADDR_CTRL 8'h10
`define ADDR_STATUS 8'h14
`define ADDR_RESULT 8'h18

// field positions inside a corner word
`define X_LSB 0
`define Y_LSB 16

// ctrl start bit
`define CTRL_START_BIT 0

`endif

//--- oflow_iou_pkg.sv
// overlap engine shared types
`include "oflow_iou_defs.svh"

package oflow_iou_pkg;

	// ----------------------------------------
	// datapath types
	// ----------------------------------------

	// one box coordinate, x or y
	typedef logic [`COORD_LEN-1:0] coord_t;

	// box area, intersection or union
	typedef logic [`AREA_LEN-1:0] area_t;

	// q0.16 ratio or distance
	typedef logic [`FRAC_LEN-1:0] ratio_t;

	// ----------------------------------------
	// controller states
	// ----------------------------------------
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_AREA,
		ST_DIVIDE,
		ST_RESULT
	} iou_state_t;

endpackage

//--- oflow_iou_apb_regs.sv
// apb register file
`include "oflow_iou_defs.svh"

module oflow_iou_apb_regs (
	input  logic                       clk,
	input  logic                       reset_N,
	input  logic                       psel,
	input  logic                       penable,
	input  logic                       pwrite,
	input  logic [`APB_ADDR_LEN-1:0]   paddr,
	input  logic [`APB_DATA_LEN-1:0]   pwdata,
	input  logic                       result_we,
	input  logic                       busy,
	input  oflow_iou_pkg::ratio_t      ratio,
	input  oflow_iou_pkg::ratio_t      distance,
	output logic [`APB_DATA_LEN-1:0]   prdata,
	output logic                       pready,
	output logic                       pslverr,
	output logic                       start,
	output logic                       irq,
	output oflow_iou_pkg::coord_t      k_x_tl,
	output oflow_iou_pkg::coord_t      k_y_tl,
	output oflow_iou_pkg::coord_t      k_x_br,
	output oflow_iou_pkg::coord_t      k_y_br,
	output oflow_iou_pkg::coord_t      h_x_tl,
	output oflow_iou_pkg::coord_t      h_y_tl,
	output oflow_iou_pkg::coord_t      h_x_br,
	output oflow_iou_pkg::coord_t      h_y_br
);
	import oflow_iou_pkg::*;

	logic                     access;
	logic                     wr_en;
	logic                     mapped;
	logic                     done;
	logic [`APB_DATA_LEN-1:0] result_q;
	logic [`APB_DATA_LEN-1:0] rd_data;

	// pack x and y into one corner word, spare bits zero
	function automatic logic [`APB_DATA_LEN-1:0] corner_word(input coord_t x, input coord_t y);
		logic [`APB_DATA_LEN-1:0] w;
		w = '0;
		w[`X_LSB +: `COORD_LEN] = x;
		w[`Y_LSB +: `COORD_LEN] = y;
		return w;
	endfunction

	// ----------------------------------------
	// apb decode
	// ----------------------------------------
	// access phase of a transfer
	assign access = psel & penable;
	// unmapped writes never land
	assign wr_en = access & pwrite & mapped;

	// read mux, also flags unmapped offsets
	always_comb begin
		mapped = 1'b1;
		rd_data = '0;
		case (paddr)
			`ADDR_K_TL: rd_data = corner_word(k_x_tl, k_y_tl);
			`ADDR_K_BR: rd_data = corner_word(k_x_br, k_y_br);
			`ADDR_H_TL: rd_data = corner_word(h_x_tl, h_y_tl);
			`ADDR_H_BR: rd_data = corner_word(h_x_br, h_y_br);
			// start is self clearing
			`ADDR_CTRL: rd_data = '0;
			// busy in bit 0, done in bit 1
			`ADDR_STATUS: rd_data = `APB_DATA_LEN'({done, busy});
			`ADDR_RESULT: rd_data = result_q;
			default: mapped = 1'b0;
		endcase
	end

	assign prdata = rd_data;
	assign pready = 1'b1;
	assign pslverr = access & ~mapped;
	assign irq = done;

	// ----------------------------------------
	// box corner registers
	// ----------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			k_x_tl <= '0;
			k_y_tl <= '0;
			k_x_br <= '0;
			k_y_br <= '0;
			h_x_tl <= '0;
			h_y_tl <= '0;
			h_x_br <= '0;
			h_y_br <= '0;
		end else if (wr_en) begin
			case (paddr)
				`ADDR_K_TL: begin
					k_x_tl <= pwdata[`X_LSB +: `COORD_LEN];
					k_y_tl <= pwdata[`Y_LSB +: `COORD_LEN];
				end
				`ADDR_K_BR: begin
					k_x_br <= pwdata[`X_LSB +: `COORD_LEN];
					k_y_br <= pwdata[`Y_LSB +: `COORD_LEN];
				end
				`ADDR_H_TL: begin
					h_x_tl <= pwdata[`X_LSB +: `COORD_LEN];
					h_y_tl <= pwdata[`Y_LSB +: `COORD_LEN];
				end
				`ADDR_H_BR: begin
					h_x_br <= pwdata[`X_LSB +: `COORD_LEN];
					h_y_br <= pwdata[`Y_LSB +: `COORD_LEN];
				end
				default: ;
			endcase
		end
	end

	// ----------------------------------------
	// start, done and result
	// ----------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			start <= 1'b0;
			done <= 1'b0;
			result_q <= '0;
		end else begin
			// one cycle pulse after the ctrl write, dropped while busy
			start <= wr_en && (paddr == `ADDR_CTRL) && pwdata[`CTRL_START_BIT] && !busy;
			// sticky until the next accepted start
			if (result_we)
				done <= 1'b1;
			else if (start)
				done <= 1'b0;
			// distance high, ratio low
			if (result_we)
				result_q <= {distance, ratio};
		end
	end

endmodule

//--- oflow_iou_ctrl.sv
// overlap scoring controller
`include "oflow_iou_defs.svh"

module oflow_iou_ctrl (
	input  logic                  clk,
	input  logic                  reset_N,
	input  logic                  start,
	input  logic                  div_done,
	input  logic [`QUOT_LEN-1:0]  quotient,
	output logic                  load_boxes,
	output logic                  div_start,
	output logic                  result_we,
	output logic                  busy,
	output oflow_iou_pkg::ratio_t ratio,
	output oflow_iou_pkg::ratio_t distance
);
	import oflow_iou_pkg::*;

	// largest q0.16 value, stands in for one
	localparam ratio_t RATIO_MAX = {`FRAC_LEN{1'b1}};

	iou_state_t state;
	iou_state_t next_state;
	ratio_t     ratio_sat;

	// ----------------------------------------
	// state register
	// ----------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			state <= ST_IDLE;
		else
			state <= next_state;
	end

	// next state
	always_comb begin
		next_state = state;
		case (state)
			// wait for an accepted start
			ST_IDLE:
				if (start)
					next_state = ST_AREA;
			// boxes latched in this cycle
			ST_AREA: next_state = ST_DIVIDE;
			// hold until the divider finishes
			ST_DIVIDE:
				if (div_done)
					next_state = ST_RESULT;
			ST_RESULT: next_state = ST_IDLE;
			default: next_state = ST_IDLE;
		endcase
	end

	// ----------------------------------------
	// stage strobes
	// ----------------------------------------
	assign load_boxes = (state == ST_AREA);
	assign result_we = (state == ST_RESULT);
	assign busy = (state != ST_IDLE);

	// div_start lands in the first divide cycle, overlap outputs valid by then
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			div_start <= 1'b0;
		else
			div_start <= (state == ST_AREA);
	end

	// ----------------------------------------
	// result forming
	// ----------------------------------------
	// quotient of exactly one clips to the max fraction
	assign ratio_sat = quotient[`QUOT_LEN-1] ? RATIO_MAX : quotient[`FRAC_LEN-1:0];

	// captured on div_done, written out in the result state
	always_ff @(posedge clk) begin
		if (div_done) begin
			ratio <= ratio_sat;
			// overlap distance, one minus iou
			distance <= RATIO_MAX - ratio_sat;
		end
	end

endmodule

//--- oflow_iou_overlap.sv
// box intersection and union datapath
`include "oflow_iou_defs.svh"

module oflow_iou_overlap (
	input  logic                  clk,
	input  logic                  reset_N,
	input  logic                  load_boxes,
	input  oflow_iou_pkg::coord_t k_x_tl,
	input  oflow_iou_pkg::coord_t k_y_tl,
	input  oflow_iou_pkg::coord_t k_x_br,
	input  oflow_iou_pkg::coord_t k_y_br,
	input  oflow_iou_pkg::coord_t h_x_tl,
	input  oflow_iou_pkg::coord_t h_y_tl,
	input  oflow_iou_pkg::coord_t h_x_br,
	input  oflow_iou_pkg::coord_t h_y_br,
	output oflow_iou_pkg::area_t  inter_area,
	output oflow_iou_pkg::area_t  union_area
);
	import oflow_iou_pkg::*;

	coord_t             k_w, k_h, h_w, h_h;
	coord_t             i_w, i_h;
	area_t              k_area, h_area, i_area;
	logic [`AREA_LEN:0] area_sum;

	function automatic coord_t coord_max(input coord_t a, input coord_t b);
		return (a > b) ? a : b;
	endfunction

	function automatic coord_t coord_min(input coord_t a, input coord_t b);
		return (a < b) ? a : b;
	endfunction

	// hi minus lo, zero when the edges cross
	function automatic coord_t span(input coord_t lo, input coord_t hi);
		return (hi > lo) ? coord_t'(hi - lo) : '0;
	endfunction

	// ----------------------------------------
	// widths and heights
	// ----------------------------------------
	assign k_w = span(k_x_tl, k_x_br);
	assign k_h = span(k_y_tl, k_y_br);
	assign h_w = span(h_x_tl, h_x_br);
	assign h_h = span(h_y_tl, h_y_br);
	// intersection rectangle, larger tl against smaller br
	assign i_w = span(coord_max(k_x_tl, h_x_tl), coord_min(k_x_br, h_x_br));
	assign i_h = span(coord_max(k_y_tl, h_y_tl), coord_min(k_y_br, h_y_br));

	// 10x10 products fit the area width
	assign k_area = k_w * k_h;
	assign h_area = h_w * h_h;
	assign i_area = i_w * i_h;
	// one extra bit before subtracting the overlap
	assign area_sum = k_area + h_area;

	// latched on load_boxes so boxes may change mid run
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			inter_area <= '0;
			union_area <= '0;
		end else if (load_boxes) begin
			inter_area <= i_area;
			union_area <= area_t'(area_sum - i_area);
		end
	end

endmodule

//--- oflow_iou_div.sv
// restoring fraction divider
`include "oflow_iou_defs.svh"

module oflow_iou_div #(
	parameter int NUM_LEN  = `AREA_LEN,
	parameter int DEN_LEN  = `AREA_LEN,
	parameter int QUOT_LEN = `QUOT_LEN
) (
	input  logic                clk,
	input  logic                reset_N,
	input  logic                div_start,
	input  logic [NUM_LEN-1:0]  numer,
	input  logic [DEN_LEN-1:0]  denom,
	output logic [QUOT_LEN-1:0] quotient,
	output logic                div_done
);
	// one integer bit above the fraction
	localparam int FRAC = QUOT_LEN - 1;
	localparam int CNT_LEN = $clog2(QUOT_LEN);

	logic [DEN_LEN:0]   rem, rem_in, trial, rem_next;
	logic [QUOT_LEN-1:0] bits, bits_in;
	logic [QUOT_LEN-1:0] quot, quot_in;
	logic [DEN_LEN-1:0] den_q, den_in;
	logic               den_zero;
	logic               running;
	logic [CNT_LEN-1:0] cnt;
	logic               step;
	logic               ge;

	// ----------------------------------------
	// one quotient bit per step
	// ----------------------------------------
	// first step runs in the div_start cycle straight off the inputs
	assign step = div_start | running;
	// numer never exceeds denom, so only the low QUOT_LEN dividend bits
	// produce quotient bits and the rest seed the remainder
	assign rem_in = div_start ? (DEN_LEN+1)'(numer >> 1) : rem;
	assign bits_in = div_start ? {numer[0], {FRAC{1'b0}}} : bits;
	assign quot_in = div_start ? '0 : quot;
	assign den_in = div_start ? denom : den_q;

	// shift in next dividend bit, trial subtract
	assign trial = {rem_in[DEN_LEN-1:0], bits_in[QUOT_LEN-1]};
	assign ge = (trial >= {1'b0, den_in});
	assign rem_next = ge ? trial - {1'b0, den_in} : trial;

	always_ff @(posedge clk) begin
		if (step) begin
			rem <= rem_next;
			bits <= {bits_in[QUOT_LEN-2:0], 1'b0};
			quot <= {quot_in[QUOT_LEN-2:0], ge};
		end
		if (div_start) begin
			den_q <= denom;
			den_zero <= (denom == '0);
		end
	end

	// empty union scores zero
	assign quotient = den_zero ? '0 : quot;

	// step counter, done one cycle after the last step
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			running <= 1'b0;
			cnt <= '0;
			div_done <= 1'b0;
		end else begin
			div_done <= 1'b0;
			if (div_start) begin
				running <= 1'b1;
				cnt <= CNT_LEN'(QUOT_LEN - 1);
			end else if (running) begin
				cnt <= cnt - 1'b1;
				if (cnt == CNT_LEN'(1)) begin
					running <= 1'b0;
					div_done <= 1'b1;
				end
			end
		end
	end

endmodule

//--- oflow_iou_top.sv
// overlap scoring engine top
`include "oflow_iou_defs.svh"

module oflow_iou_top (
	input  logic                     clk,
	input  logic                     reset_N,
	input  logic                     psel,
	input  logic                     penable,
	input  logic                     pwrite,
	input  logic [`APB_ADDR_LEN-1:0] paddr,
	input  logic [`APB_DATA_LEN-1:0] pwdata,
	output logic [`APB_DATA_LEN-1:0] prdata,
	output logic                     pready,
	output logic                     pslverr,
	output logic                     irq
);
	import oflow_iou_pkg::*;

	// ----------------------------------------
	// internal nets
	// ----------------------------------------
	// box corners, register file to overlap
	coord_t               k_x_tl, k_y_tl, k_x_br, k_y_br;
	coord_t               h_x_tl, h_y_tl, h_x_br, h_y_br;
	// control strobes
	logic                 start, load_boxes, div_start, div_done;
	logic                 result_we, busy;
	// datapath values
	area_t                inter_area, union_area;
	logic [`QUOT_LEN-1:0] quotient;
	ratio_t               ratio, distance;

	oflow_iou_apb_regs u_regs (
		.clk(clk), .reset_N(reset_N),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.result_we(result_we), .busy(busy), .ratio(ratio), .distance(distance),
		.prdata(prdata), .pready(pready), .pslverr(pslverr), .start(start), .irq(irq),
		.k_x_tl(k_x_tl), .k_y_tl(k_y_tl), .k_x_br(k_x_br), .k_y_br(k_y_br),
		.h_x_tl(h_x_tl), .h_y_tl(h_y_tl), .h_x_br(h_x_br), .h_y_br(h_y_br)
	);

	oflow_iou_ctrl u_ctrl (
		.clk(clk), .reset_N(reset_N), .start(start),
		.div_done(div_done), .quotient(quotient),
		.load_boxes(load_boxes), .div_start(div_start), .result_we(result_we),
		.busy(busy), .ratio(ratio), .distance(distance)
	);

	oflow_iou_overlap u_overlap (
		.clk(clk), .reset_N(reset_N), .load_boxes(load_boxes),
		.k_x_tl(k_x_tl), .k_y_tl(k_y_tl), .k_x_br(k_x_br), .k_y_br(k_y_br),
		.h_x_tl(h_x_tl), .h_y_tl(h_y_tl), .h_x_br(h_x_br), .h_y_br(h_y_br),
		.inter_area(inter_area), .union_area(union_area)
	);

	// intersection over union, q0.16 plus one integer bit
	oflow_iou_div #(
		.NUM_LEN(`AREA_LEN), .DEN_LEN(`AREA_LEN), .QUOT_LEN(`QUOT_LEN)
	) u_div (
		.clk(clk), .reset_N(reset_N), .div_start(div_start),
		.numer(inter_area), .denom(union_area),
		.quotient(quotient), .div_done(div_done)
	);

endmodule

//--- oflow_iou_props.sv
// apb and completion assertions
`include "oflow_iou_defs.svh"

module oflow_iou_props (
	input logic                     clk,
	input logic                     reset_N,
	input logic                     psel,
	input logic                     penable,
	input logic                     pwrite,
	input logic [`APB_ADDR_LEN-1:0] paddr,
	input logic [`APB_DATA_LEN-1:0] pwdata,
	input logic [`APB_DATA_LEN-1:0] prdata,
	input logic                     pready,
	input logic                     pslverr,
	input logic                     irq,
	input logic                     busy
);
	timeunit 1ns;
	timeprecision 100ps;

	// cycles from an accepted start write to the done edge
	localparam logic [5:0] DONE_LIMIT = 6'd25;

	logic       access;
	logic       status_busy;
	logic       start_wr;
	logic       wait_done;
	logic [5:0] wait_cnt;
	logic       irq_q;
	int         slverr_fails = 0;
	int         ready_fails = 0;
	int         irq_fails = 0;
	int         done_fails = 0;

	assign access = psel & penable;
	// status read that still shows the engine busy
	assign status_busy = access & ~pwrite & (paddr == `ADDR_STATUS) & prdata[0];
	// start write the register file accepts
	assign start_wr = access & pwrite & (paddr == `ADDR_CTRL) & pwdata[`CTRL_START_BIT] & ~busy;

	// ----------------------------------------
	// start to done tracking
	// ----------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			wait_done <= 1'b0;
			wait_cnt <= '0;
			irq_q <= 1'b0;
		end else begin
			irq_q <= irq;
			if (start_wr) begin
				wait_done <= 1'b1;
				wait_cnt <= '0;
			end else if (wait_done) begin
				// an old done may still be high, wait for the new edge
				if (irq & ~irq_q)
					wait_done <= 1'b0;
				else
					wait_cnt <= wait_cnt + 6'd1;
			end
		end
	end

	// ----------------------------------------
	// properties
	// ----------------------------------------
	slverr_in_access: assert property (@(posedge clk) disable iff (!reset_N)
		pslverr |-> access)
		else begin
			slverr_fails++;
			$error("pslverr high outside an access cycle");
		end

	ready_high: assert property (@(posedge clk) disable iff (!reset_N) pready)
		else begin
			ready_fails++;
			$error("pready dropped low");
		end

	irq_not_busy: assert property (@(posedge clk) disable iff (!reset_N)
		$rose(irq) |-> !status_busy)
		else begin
			irq_fails++;
			$error("irq rose while a status read showed busy");
		end

	done_in_time: assert property (@(posedge clk) disable iff (!reset_N)
		wait_done |-> (wait_cnt < DONE_LIMIT))
		else begin
			done_fails++;
			$error("done did not rise within the run limit after a start");
		end

endmodule

bind oflow_iou_top oflow_iou_props u_props (
	.clk(clk), .reset_N(reset_N),
	.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
	.prdata(prdata), .pready(pready), .pslverr(pslverr), .irq(irq), .busy(busy)
);

//--- oflow_iou_clkgen.sv
// testbench clock and reset
module oflow_iou_clkgen #(
	parameter int PERIOD = 20,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic reset_N
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		reset_N = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset_N = 1'b1;
	end

endmodule

//--- oflow_iou_tb.sv
// overlap engine testbench
`include "oflow_iou_defs.svh"

module oflow_iou_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_NS = 20;
	// status polls before a run counts as hung
	localparam int POLL_MAX = 40;
	// table, edge, random and control runs
	localparam int NUM_RUNS = 4 + 3 + 20 + 2;
	// four cycles per transfer, six transfers plus polls per run
	localparam int RUN_CYCLES = (POLL_MAX + 8) * 4;
	localparam int WATCHDOG_NS = (NUM_RUNS * RUN_CYCLES + 400) * CLK_NS;
	// x in 9..0, y in 25..16
	localparam logic [31:0] CORNER_MASK = 32'h03FF_03FF;

	logic                     clk;
	logic                     reset_N;
	logic                     psel;
	logic                     penable;
	logic                     pwrite;
	logic [`APB_ADDR_LEN-1:0] paddr;
	logic [`APB_DATA_LEN-1:0] pwdata;
	logic [`APB_DATA_LEN-1:0] prdata;
	logic                     pready;
	logic                     pslverr;
	logic                     irq;
	logic                     last_slverr;
	int                       seed;
	int                       poll_skew;
	string                    test_name;
	int                       test_checks;
	int                       test_errors;
	int                       num_tests;
	int                       total_checks;
	int                       total_errors;

	oflow_iou_clkgen #(.PERIOD(CLK_NS), .RESET_CYCLES(3)) u_clkgen (
		.clk(clk), .reset_N(reset_N)
	);

	oflow_iou_top uut (
		.clk(clk), .reset_N(reset_N),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr), .irq(irq)
	);

	// ----------------------------------------
	// apb access
	// ----------------------------------------
	// setup, access, then the bus idles
	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		// mid access cycle, all outputs settled
		#1;
		rdata = prdata;
		last_slverr = pslverr;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		apb_xfer(1'b1, addr, data, unused);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		apb_xfer(1'b0, addr, '0, data);
	endtask

	// ----------------------------------------
	// checking and bookkeeping
	// ----------------------------------------
	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		test_checks++;
		assert (actual === expected)
		else begin
			test_errors++;
			$display("Error %s %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic end_test();
		$display("test %s: %0d checks, %0d errors, %s", test_name, test_checks, test_errors,
			(test_errors == 0) ? "passed" : "failed");
		num_tests++;
		total_checks += test_checks;
		total_errors += test_errors;
	endtask

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic logic [31:0] corner_word(input int x, input int y);
		return {6'd0, y[9:0], 6'd0, x[9:0]};
	endfunction

	// box side, zero when br lies below tl
	function automatic longint side(input int lo, input int hi);
		return (hi > lo) ? longint'(hi - lo) : 0;
	endfunction

	// expected RESULT word, distance high and ratio low
	function automatic logic [31:0] expected_result(input int kx0, ky0, kx1, ky1,
			hx0, hy0, hx1, hy1);
		longint i_area;
		longint u_area;
		longint ratio;
		// smaller br against larger tl
		i_area = side((kx0 > hx0) ? kx0 : hx0, (kx1 < hx1) ? kx1 : hx1)
			* side((ky0 > hy0) ? ky0 : hy0, (ky1 < hy1) ? ky1 : hy1);
		u_area = side(kx0, kx1) * side(ky0, ky1) + side(hx0, hx1) * side(hy0, hy1) - i_area;
		if (u_area == 0)
			ratio = 0;
		else
			ratio = (i_area * 65536) / u_area;
		if (ratio > 65535)
			ratio = 65535;
		return {16'(65535 - ratio), 16'(ratio)};
	endfunction

	// ----------------------------------------
	// run helpers
	// ----------------------------------------
	task automatic load_pair(input int kx0, ky0, kx1, ky1, hx0, hy0, hx1, hy1);
		apb_write(`ADDR_K_TL, corner_word(kx0, ky0));
		apb_write(`ADDR_K_BR, corner_word(kx1, ky1));
		apb_write(`ADDR_H_TL, corner_word(hx0, hy0));
		apb_write(`ADDR_H_BR, corner_word(hx1, hy1));
	endtask

	task automatic wait_for_done();
		logic [31:0] status;
		int          polls;
		polls = 0;
		status = '0;
		// idle cycles shift the polls against the done edge
		repeat (poll_skew) @(negedge clk);
		while (!status[1] && polls < POLL_MAX) begin
			apb_read(`ADDR_STATUS, status);
			polls++;
		end
		if (!status[1]) begin
			test_errors++;
			$display("%s: done flag never set after a start", test_name);
		end
	endtask

	task automatic score_pair(input string what, input int kx0, ky0, kx1, ky1,
			hx0, hy0, hx1, hy1);
		logic [31:0] data;
		load_pair(kx0, ky0, kx1, ky1, hx0, hy0, hx1, hy1);
		apb_write(`ADDR_CTRL, 32'h1);
		wait_for_done();
		check_value({what, " irq"}, 32'h1, {31'd0, irq});
		apb_read(`ADDR_RESULT, data);
		check_value({what, " result"},
			expected_result(kx0, ky0, kx1, ky1, hx0, hy0, hx1, hy1), data);
	endtask

	// ----------------------------------------
	// tests
	// ----------------------------------------
	task automatic reset_test();
		logic [31:0] data;
		logic [7:0]  addr;
		begin_test("reset");
		// corners, ctrl, status and result
		for (int i = 0; i <= 6; i++) begin
			addr = 8'(i * 4);
			apb_read(addr, data);
			check_value($sformatf("offset %h", addr), 32'h0, data);
		end
		check_value("irq", 32'h0, {31'd0, irq});
		end_test();
	endtask

	task automatic register_test();
		logic [31:0] data;
		logic [31:0] pattern [4];
		begin_test("register access");
		pattern[0] = 32'hFFFF_FFFF;
		pattern[1] = 32'hA5A5_5A5A;
		pattern[2] = 32'h1234_5678;
		pattern[3] = 32'hFC00_FC00;
		for (int i = 0; i < 4; i++) begin
			apb_write(8'(i * 4), pattern[i]);
			check_value("corner write slverr", 32'h0, {31'd0, last_slverr});
		end
		// start bit just off the ctrl offset
		apb_write(8'h11, 32'h1);
		check_value("unmapped write slverr", 32'h1, {31'd0, last_slverr});
		apb_write(8'h1C, 32'hFFFF_FFFF);
		check_value("unmapped write slverr", 32'h1, {31'd0, last_slverr});
		apb_read(8'h40, data);
		check_value("unmapped read slverr", 32'h1, {31'd0, last_slverr});
		for (int i = 0; i < 4; i++) begin
			apb_read(8'(i * 4), data);
			check_value($sformatf("corner %0d readback", i), pattern[i] & CORNER_MASK, data);
		end
		apb_read(`ADDR_STATUS, data);
		check_value("status after unmapped writes", 32'h0, data);
		end_test();
	endtask

	task automatic random_test();
		int kx0;
		int ky0;
		int hx0;
		int hy0;
		int kx1;
		int ky1;
		int hx1;
		int hy1;
		begin_test("random pairs");
		for (int i = 0; i < 20; i++) begin
			kx0 = 100 + rand_below(512);
			ky0 = 100 + rand_below(512);
			// history box close by so most pairs overlap
			hx0 = kx0 + rand_below(200) - 100;
			hy0 = ky0 + rand_below(200) - 100;
			kx1 = kx0 + rand_below(300);
			ky1 = ky0 + rand_below(300);
			hx1 = hx0 + rand_below(300);
			hy1 = hy0 + rand_below(300);
			// every poll phase, so some status read meets the irq edge
			poll_skew = i % 3;
			score_pair($sformatf("pair %0d", i), kx0, ky0, kx1, ky1, hx0, hy0, hx1, hy1);
		end
		poll_skew = 0;
		end_test();
	endtask

	task automatic control_test();
		logic [31:0] data;
		begin_test("control");
		load_pair(10, 10, 50, 50, 30, 30, 70, 70);
		apb_write(`ADDR_CTRL, 32'h1);
		apb_read(`ADDR_STATUS, data);
		check_value("status after start", 32'h1, data);
		// new boxes while busy, then a start that must be dropped
		// a restart here would latch the new boxes
		load_pair(0, 0, 100, 40, 20, 10, 60, 80);
		apb_write(`ADDR_CTRL, 32'h1);
		wait_for_done();
		apb_read(`ADDR_RESULT, data);
		check_value("result after start while busy",
			expected_result(10, 10, 50, 50, 30, 30, 70, 70), data);
		apb_write(`ADDR_CTRL, 32'h1);
		apb_read(`ADDR_STATUS, data);
		check_value("done after restart", 32'h0, {31'd0, data[1]});
		check_value("irq after restart", 32'h0, {31'd0, irq});
		wait_for_done();
		apb_read(`ADDR_RESULT, data);
		check_value("result after restart", expected_result(0, 0, 100, 40, 20, 10, 60, 80), data);
		end_test();
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		int props_fails;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		last_slverr = 1'b0;
		seed = 32'h9e52a628;
		poll_skew = 0;
		num_tests = 0;
		total_checks = 0;
		total_errors = 0;
		@(posedge reset_N);
		reset_test();
		register_test();
		begin_test("overlap table");
		score_pair("shifted", 10, 10, 50, 50, 30, 30, 70, 70);
		score_pair("crossing", 0, 0, 100, 40, 20, 10, 60, 80);
		score_pair("contained", 200, 100, 400, 300, 250, 150, 300, 200);
		score_pair("far corner", 1000, 1000, 1023, 1023, 990, 995, 1010, 1020);
		end_test();
		begin_test("edge cases");
		score_pair("disjoint", 0, 0, 10, 10, 20, 20, 30, 30);
		score_pair("identical", 5, 7, 105, 207, 5, 7, 105, 207);
		score_pair("zero area", 40, 40, 40, 90, 40, 40, 40, 90);
		end_test();
		random_test();
		control_test();
		props_fails = uut.u_props.slverr_fails + uut.u_props.ready_fails
			+ uut.u_props.irq_fails + uut.u_props.done_fails;
		if (props_fails != 0)
			$display("concurrent assertions failed %0d times", props_fails);
		total_errors += props_fails;
		$display("tests: %0d, checks: %0d, errors: %0d", num_tests, total_checks, total_errors);
		if (total_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- sources.f
+incdir+.
oflow_iou_pkg.sv
oflow_iou_apb_regs.sv
oflow_iou_ctrl.sv
oflow_iou_overlap.sv
oflow_iou_div.sv
oflow_iou_top.sv
oflow_iou_props.sv
oflow_iou_clkgen.sv
oflow_iou_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module oflow_iou_tb -f sources.f -o oflow_iou_sim

# let assertion failures reach the testbench summary
./obj_dir/oflow_iou_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

grep -qx "ALL CHECKS PASSED" sim.log
